// ==== verilog/mmc_pkg.sv ====
// Byte-addressed standard-capacity cards only, 512-byte blocks, CRC checked only on CMD0
package mmc_pkg;

	// Host command codes, the upper two are accepted and ignored
	typedef enum logic [1:0] {
		cmd_reset = 2'd0,
		cmd_read  = 2'd1,
		cmd_rsvd2 = 2'd2,
		cmd_rsvd3 = 2'd3
	} host_cmd_e;

	// 48-bit SPI command frame, sent MSB first
	typedef struct packed {
		logic [7:0]  index_byte;
		logic [31:0] arg;
		logic [7:0]  crc_byte;
	} mmc_frame_t;

	// Byte engine operations
	typedef enum logic [2:0] {
		op_none = 3'd0,
		op_wake = 3'd1,
		op_send = 3'd2,
		op_read = 3'd3,
		op_stop = 3'd4
	} eng_op_e;

	typedef struct packed {
		eng_op_e    op;
		mmc_frame_t frame;
	} eng_req_t;

	// Block geometry
	localparam int BLOCK_BYTES_LOG2 = 9;
	localparam int WORDS_PER_BLOCK = 256;

	// CRC is ignored by the card in SPI mode once CMD0 is through
	localparam logic [7:0] CRC_NONE = 8'h01;

	// Fixed command frames
	localparam mmc_frame_t CMD0_FRAME = '{
		index_byte: 8'h40,
		arg: 32'h0000_0000,
		crc_byte: 8'h95
	};
	localparam mmc_frame_t CMD1_FRAME = '{
		index_byte: 8'h41,
		arg: 32'h0000_0000,
		crc_byte: CRC_NONE
	};
	// Block length of 512 bytes
	localparam mmc_frame_t CMD16_FRAME = '{
		index_byte: 8'h50,
		arg: 32'(1 << BLOCK_BYTES_LOG2),
		crc_byte: CRC_NONE
	};
	localparam logic [7:0] CMD17_INDEX = 8'h51;
	localparam mmc_frame_t DUMMY_FRAME = '1;

	// R1 and data phase bytes
	localparam logic [7:0] R1_IDLE = 8'h01;
	localparam logic [7:0] R1_READY = 8'h00;
	localparam logic [7:0] BYTE_IDLE = 8'hFF;
	localparam logic [7:0] DATA_TOKEN = 8'hFE;

endpackage

// ==== verilog/spi_byte_engine.sv ====
// SPI mode 0 only; one fixed SCLK divider, SCLK_HALF must be 1 or more; one op at a time
`timescale 1ns/1ps

module spi_byte_engine #(
	parameter int SCLK_HALF = 2
) (
	input  logic              clk,
	input  logic              reset,
	input  mmc_pkg::eng_req_t eng_req,
	input  logic              mmc_di,
	output logic              eng_done,
	output logic [7:0]        rx_byte,
	output logic              mmc_cs,
	output logic              mmc_sclk,
	output logic              mmc_do
);
	import mmc_pkg::*;

	localparam int DIV_W = $clog2(SCLK_HALF + 1);
	localparam logic [DIV_W-1:0] HALF_LAST = DIV_W'(SCLK_HALF - 1);

	// SCLK periods per operation
	localparam logic [6:0] SEND_CLKS = 7'd48;
	localparam logic [6:0] READ_CLKS = 7'd8;
	localparam logic [6:0] WAKE_CLKS = 7'd80;
	localparam logic [6:0] STOP_CLKS = 7'd8;

	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	logic [6:0]       clk_cnt;
	logic [6:0]       op_len;
	logic [47:0]      load_word;
	logic [47:0]      tx_shift;
	logic [7:0]       rx_shift;
	logic             accept;
	logic             half_end;

	assign accept = !busy && (eng_req.op != op_none);
	assign half_end = busy && (div_cnt == HALF_LAST);
	assign eng_done = !busy;
	assign rx_byte = rx_shift;

	always_comb begin
		op_len = READ_CLKS;
		// Only a send puts a frame on MOSI, all else clocks out ones
		load_word = '1;
		case (eng_req.op)
			op_send: begin
				op_len = SEND_CLKS;
				load_word = eng_req.frame;
			end
			op_wake: op_len = WAKE_CLKS;
			op_stop: op_len = STOP_CLKS;
			default: op_len = READ_CLKS;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			div_cnt <= '0;
			clk_cnt <= '0;
			mmc_cs <= 1'b1;
			mmc_sclk <= 1'b0;
			mmc_do <= 1'b1;
		end else if (accept) begin
			busy <= 1'b1;
			div_cnt <= '0;
			clk_cnt <= op_len;
			mmc_do <= load_word[47];
			// Select stays low from a send or read until a stop or wake
			mmc_cs <= (eng_req.op == op_wake) || (eng_req.op == op_stop);
		end else if (half_end) begin
			div_cnt <= '0;
			mmc_sclk <= !mmc_sclk;
			if (mmc_sclk) begin
				// Falling edge, next bit out
				mmc_do <= tx_shift[46];
				clk_cnt <= clk_cnt - 7'd1;
				if (clk_cnt == 7'd1)
					busy <= 1'b0;
			end
		end else if (busy) begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Shift registers
	always_ff @(posedge clk) begin
		if (accept)
			tx_shift <= load_word;
		else if (half_end && mmc_sclk)
			tx_shift <= {tx_shift[46:0], 1'b1};
		// Sample MISO as SCLK rises
		if (half_end && !mmc_sclk)
			rx_shift <= {rx_shift[6:0], mmc_di};
	end

endmodule

// ==== verilog/blk_cmd_decode.sv ====
// Byte addressing only, so block addresses are limited to 23 bits; inited clears only on reset
`timescale 1ns/1ps

module blk_cmd_decode (
	input  logic                clk,
	input  logic                reset,
	input  mmc_pkg::host_cmd_e  bd_cmd,
	input  logic [22:0]         bd_addr,
	input  logic                bd_start,
	input  logic                set_inited,
	input  logic                next_block,
	output logic                req_valid,
	output mmc_pkg::host_cmd_e  req_cmd,
	output logic [31:0]         byte_addr,
	output logic                inited
);
	import mmc_pkg::*;

	localparam logic [31:0] BLOCK_STEP = 32'(1 << BLOCK_BYTES_LOG2);

	// Start pulse and command, one cycle behind the host
	always_ff @(posedge clk) begin
		if (reset) begin
			req_valid <= 1'b0;
			req_cmd <= cmd_reset;
		end else begin
			req_valid <= bd_start;
			// Command held for the whole request
			if (bd_start)
				req_cmd <= bd_cmd;
		end
	end

	// Card byte address of the current block
	always_ff @(posedge clk) begin
		if (bd_start)
			byte_addr <= {bd_addr, {BLOCK_BYTES_LOG2{1'b0}}};
		else if (next_block)
			byte_addr <= byte_addr + BLOCK_STEP;
	end

	// Sticky once the card has accepted CMD16
	always_ff @(posedge clk) begin
		if (reset)
			inited <= 1'b0;
		else if (set_inited)
			inited <= 1'b1;
	end

endmodule

// ==== verilog/blk_sequencer.sv ====
// R1 and token polls are unbounded, a card that never answers keeps the request busy
`timescale 1ns/1ps

module blk_sequencer #(
	parameter int BLOCKS_PER_REQ = 2
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               req_valid,
	input  mmc_pkg::host_cmd_e req_cmd,
	input  logic [31:0]        byte_addr,
	input  logic               inited,
	input  logic               eng_done,
	input  logic [7:0]         rx_byte,
	input  logic               bd_rd,
	input  logic               last_word,
	input  logic               last_block,
	output mmc_pkg::eng_req_t  eng_req,
	output logic               set_inited,
	output logic               next_block,
	output logic               capture_lo,
	output logic               capture_hi,
	output logic               word_take,
	output logic               block_start,
	output logic               block_end,
	output logic               err_set,
	output logic               bd_bsy,
	output logic               bd_rdy,
	output logic               bd_iordy
);
	import mmc_pkg::*;

	typedef enum logic [4:0] {
		st_idle, st_wake, st_cmd0, st_resp0, st_stop0,
		st_cmd1, st_resp1, st_retry1, st_stop1,
		st_cmd16, st_resp16, st_stop16,
		st_dummy, st_cmd17, st_resp17, st_abort, st_token,
		st_lo, st_hi, st_host, st_crc0, st_crc1, st_stop17
	} state_e;

	state_e     state;
	state_e     state_next;
	eng_op_e    op_sel;
	logic       op_pend;
	logic       op_done;
	logic       final_block;

	// Engine has taken the op and finished it
	assign op_done = op_pend && eng_done;
	// Single-block requests never advance
	assign final_block = (BLOCKS_PER_REQ == 1) || last_block;

	assign bd_rdy = (state == st_idle) || (state == st_host);
	assign bd_iordy = (state == st_host);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			op_pend <= 1'b0;
			bd_bsy <= 1'b0;
		end else begin
			state <= state_next;
			bd_bsy <= (state != st_idle);
			if (op_done)
				op_pend <= 1'b0;
			else if (op_sel != op_none && !eng_done)
				op_pend <= 1'b1;
		end
	end

	always_comb begin
		state_next = state;
		op_sel = op_none;
		eng_req.frame = DUMMY_FRAME;
		set_inited = 1'b0;
		next_block = 1'b0;
		capture_lo = 1'b0;
		capture_hi = 1'b0;
		word_take = 1'b0;
		block_start = 1'b0;
		block_end = 1'b0;
		err_set = 1'b0;
		case (state)
			st_idle: begin
				if (req_valid && req_cmd == cmd_reset)
					state_next = st_wake;
				else if (req_valid && req_cmd == cmd_read)
					state_next = inited ? st_dummy : st_wake;
			end
			// Initialisation
			st_wake: begin
				op_sel = op_wake;
				if (op_done)
					state_next = st_cmd0;
			end
			st_cmd0: begin
				op_sel = op_send;
				eng_req.frame = CMD0_FRAME;
				if (op_done)
					state_next = st_resp0;
			end
			st_resp0: begin
				op_sel = op_read;
				if (op_done && rx_byte == R1_IDLE)
					state_next = st_stop0;
				else if (op_done && !rx_byte[7])
					state_next = st_wake;
			end
			st_stop0: begin
				op_sel = op_stop;
				if (op_done)
					state_next = st_cmd1;
			end
			st_cmd1: begin
				op_sel = op_send;
				eng_req.frame = CMD1_FRAME;
				if (op_done)
					state_next = st_resp1;
			end
			st_resp1: begin
				op_sel = op_read;
				if (op_done && rx_byte == R1_READY)
					state_next = st_stop1;
				else if (op_done && rx_byte != BYTE_IDLE)
					state_next = st_retry1;
			end
			st_retry1: begin
				op_sel = op_stop;
				if (op_done)
					state_next = st_cmd1;
			end
			st_stop1: begin
				op_sel = op_stop;
				if (op_done)
					state_next = st_cmd16;
			end
			st_cmd16: begin
				op_sel = op_send;
				eng_req.frame = CMD16_FRAME;
				if (op_done)
					state_next = st_resp16;
			end
			st_resp16: begin
				op_sel = op_read;
				if (op_done && rx_byte == R1_READY)
					state_next = st_stop16;
			end
			st_stop16: begin
				op_sel = op_stop;
				if (op_done) begin
					set_inited = 1'b1;
					// A read that found the card cold carries on here
					state_next = (req_cmd == cmd_read) ? st_dummy : st_idle;
				end
			end
			// Block read
			st_dummy: begin
				op_sel = op_send;
				if (op_done)
					state_next = st_cmd17;
			end
			st_cmd17: begin
				op_sel = op_send;
				eng_req.frame = '{index_byte: CMD17_INDEX, arg: byte_addr, crc_byte: CRC_NONE};
				if (op_done)
					state_next = st_resp17;
			end
			st_resp17: begin
				op_sel = op_read;
				if (op_done && rx_byte == R1_READY) begin
					block_start = 1'b1;
					state_next = st_token;
				end else if (op_done && rx_byte != BYTE_IDLE) begin
					err_set = 1'b1;
					state_next = st_abort;
				end
			end
			st_abort: begin
				op_sel = op_stop;
				if (op_done)
					state_next = st_idle;
			end
			st_token: begin
				op_sel = op_read;
				if (op_done && rx_byte == DATA_TOKEN)
					state_next = st_lo;
			end
			st_lo: begin
				op_sel = op_read;
				capture_lo = op_done;
				if (op_done)
					state_next = st_hi;
			end
			st_hi: begin
				op_sel = op_read;
				capture_hi = op_done;
				if (op_done)
					state_next = st_host;
			end
			// Word on offer until the host takes it
			st_host: begin
				word_take = bd_rd;
				if (bd_rd)
					state_next = last_word ? st_crc0 : st_lo;
			end
			st_crc0: begin
				op_sel = op_read;
				if (op_done)
					state_next = st_crc1;
			end
			st_crc1: begin
				op_sel = op_read;
				if (op_done)
					state_next = st_stop17;
			end
			st_stop17: begin
				op_sel = op_stop;
				if (op_done) begin
					block_end = 1'b1;
					next_block = 1'b1;
					state_next = final_block ? st_idle : st_dummy;
				end
			end
			default: state_next = st_idle;
		endcase
		// Request withdrawn once the engine has taken it
		if (op_pend)
			eng_req.op = op_none;
		else
			eng_req.op = op_sel;
	end

endmodule

// ==== verilog/blk_read_result.sv ====
// Counts assume strobes from the sequencer only; an error also rewinds the block count
`timescale 1ns/1ps

module blk_read_result #(
	parameter int BLOCKS_PER_REQ = 2
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [7:0]  rx_byte,
	input  logic        capture_lo,
	input  logic        capture_hi,
	input  logic        word_take,
	input  logic        block_start,
	input  logic        block_end,
	input  logic        err_set,
	output logic [15:0] bd_data_out,
	output logic        last_word,
	output logic        last_block,
	output logic        bd_err
);
	import mmc_pkg::*;

	localparam int WORD_W = $clog2(WORDS_PER_BLOCK);
	localparam int BLK_W = (BLOCKS_PER_REQ > 1) ? $clog2(BLOCKS_PER_REQ) : 1;

	logic [WORD_W-1:0] word_cnt;
	logic [BLK_W-1:0]  block_cnt;

	assign last_word = (word_cnt == WORD_W'(WORDS_PER_BLOCK - 1));
	assign last_block = (block_cnt == BLK_W'(BLOCKS_PER_REQ - 1));

	// First byte of the pair lands low
	always_ff @(posedge clk) begin
		if (capture_lo)
			bd_data_out[7:0] <= rx_byte;
		if (capture_hi)
			bd_data_out[15:8] <= rx_byte;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			word_cnt <= '0;
			block_cnt <= '0;
			bd_err <= 1'b0;
		end else begin
			bd_err <= err_set;
			if (block_start)
				word_cnt <= '0;
			else if (word_take)
				word_cnt <= word_cnt + 1'b1;
			// Wraps after the last block so the next request starts at zero
			if (err_set || (block_end && last_block))
				block_cnt <= '0;
			else if (block_end)
				block_cnt <= block_cnt + 1'b1;
		end
	end

endmodule

// ==== verilog/block_dev_mmc.sv ====
// Read and reset commands only; a read fetches BLOCKS_PER_REQ consecutive 512-byte blocks
`timescale 1ns/1ps

module block_dev_mmc #(
	parameter int BLOCKS_PER_REQ = 2,
	parameter int SCLK_HALF = 2
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [1:0]  bd_cmd,
	input  logic [22:0] bd_addr,
	input  logic        bd_start,
	input  logic        bd_rd,
	input  logic        mmc_di,
	output logic [15:0] bd_data_out,
	output logic        bd_bsy,
	output logic        bd_rdy,
	output logic        bd_iordy,
	output logic        bd_err,
	output logic        mmc_cs,
	output logic        mmc_do,
	output logic        mmc_sclk
);
	import mmc_pkg::*;

	logic        req_valid;
	host_cmd_e   req_cmd;
	logic [31:0] byte_addr;
	logic        inited;
	logic        set_inited;
	logic        next_block;
	eng_req_t    eng_req;
	logic        eng_done;
	logic [7:0]  rx_byte;
	logic        capture_lo;
	logic        capture_hi;
	logic        word_take;
	logic        block_start;
	logic        block_end;
	logic        err_set;
	logic        last_word;
	logic        last_block;

	blk_cmd_decode i_decode (
		.clk        (clk),
		.reset      (reset),
		.bd_cmd     (host_cmd_e'(bd_cmd)),
		.bd_addr    (bd_addr),
		.bd_start   (bd_start),
		.set_inited (set_inited),
		.next_block (next_block),
		.req_valid  (req_valid),
		.req_cmd    (req_cmd),
		.byte_addr  (byte_addr),
		.inited     (inited)
	);

	blk_sequencer #(
		.BLOCKS_PER_REQ (BLOCKS_PER_REQ)
	) i_sequencer (
		.clk         (clk),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_cmd     (req_cmd),
		.byte_addr   (byte_addr),
		.inited      (inited),
		.eng_done    (eng_done),
		.rx_byte     (rx_byte),
		.bd_rd       (bd_rd),
		.last_word   (last_word),
		.last_block  (last_block),
		.eng_req     (eng_req),
		.set_inited  (set_inited),
		.next_block  (next_block),
		.capture_lo  (capture_lo),
		.capture_hi  (capture_hi),
		.word_take   (word_take),
		.block_start (block_start),
		.block_end   (block_end),
		.err_set     (err_set),
		.bd_bsy      (bd_bsy),
		.bd_rdy      (bd_rdy),
		.bd_iordy    (bd_iordy)
	);

	blk_read_result #(
		.BLOCKS_PER_REQ (BLOCKS_PER_REQ)
	) i_result (
		.clk         (clk),
		.reset       (reset),
		.rx_byte     (rx_byte),
		.capture_lo  (capture_lo),
		.capture_hi  (capture_hi),
		.word_take   (word_take),
		.block_start (block_start),
		.block_end   (block_end),
		.err_set     (err_set),
		.bd_data_out (bd_data_out),
		.last_word   (last_word),
		.last_block  (last_block),
		.bd_err      (bd_err)
	);

	spi_byte_engine #(
		.SCLK_HALF (SCLK_HALF)
	) i_engine (
		.clk      (clk),
		.reset    (reset),
		.eng_req  (eng_req),
		.mmc_di   (mmc_di),
		.eng_done (eng_done),
		.rx_byte  (rx_byte),
		.mmc_cs   (mmc_cs),
		.mmc_sclk (mmc_sclk),
		.mmc_do   (mmc_do)
	);

endmodule

// ==== dv/sd_card_model.sv ====
// SPI mode 0 card model for CMD0, CMD1, CMD16 and CMD17 only, CRC ignored, log keeps 64 frames
`timescale 1ns/1ps

module sd_card_model #(
	parameter logic [31:0] POISON_ADDR = 32'h0
) (
	input  logic mmc_cs,
	input  logic mmc_sclk,
	input  logic mmc_do,
	output logic mmc_di
);
	import mmc_pkg::*;

	localparam int LOG_DEPTH = 64;

	// Index byte and argument of each frame, oldest first
	logic [39:0] log_mem [0:LOG_DEPTH-1];
	int          log_count;
	logic [7:0]  out_q [$];
	logic [7:0]  rx_sh;
	logic [7:0]  tx_sh;
	logic [47:0] frame;
	int          bit_cnt;
	int          frame_bytes;
	int          cmd1_count;

	initial begin
		mmc_di = 1'b1;
		log_count = 0;
		bit_cnt = 0;
		frame_bytes = 0;
		cmd1_count = 0;
		rx_sh = 8'hFF;
		tx_sh = 8'hFF;
		frame = '1;
	end

	function automatic void answer(input logic [47:0] f);
		logic [5:0]  cmd;
		logic [31:0] arg;
		int          i;
		cmd = f[45:40];
		arg = f[39:8];
		if (log_count < LOG_DEPTH)
			log_mem[log_count] = f[47:8];
		log_count++;
		case (cmd)
			6'd0: begin
				cmd1_count = 0;
				out_q.push_back(R1_IDLE);
			end
			6'd1: begin
				// Card stays idle for the first two polls
				cmd1_count++;
				if (cmd1_count > 2)
					out_q.push_back(R1_READY);
				else
					out_q.push_back(R1_IDLE);
			end
			6'd16: out_q.push_back(R1_READY);
			6'd17: begin
				if (arg == POISON_ADDR) begin
					out_q.push_back(8'h04);
				end else begin
					out_q.push_back(R1_READY);
					out_q.push_back(DATA_TOKEN);
					for (i = 0; i < 512; i++)
						out_q.push_back(8'(arg + 32'(i)));
					// Block CRC, never checked
					out_q.push_back(8'hC3);
					out_q.push_back(8'h3C);
				end
			end
			default: out_q.push_back(8'h04);
		endcase
	endfunction

	// All-ones bytes between frames are filler
	function automatic void take_byte(input logic [7:0] b);
		if (frame_bytes != 0 || b != BYTE_IDLE) begin
			frame = {frame[39:0], b};
			frame_bytes++;
			if (frame_bytes == 6) begin
				frame_bytes = 0;
				answer(frame);
			end
		end
	endfunction

	always @(posedge mmc_sclk or negedge mmc_sclk or posedge mmc_cs) begin
		if (mmc_cs) begin
			// Deselect drops unsent bytes and realigns
			bit_cnt = 0;
			frame_bytes = 0;
			out_q.delete();
			tx_sh = 8'hFF;
			mmc_di = 1'b1;
		end else if (mmc_sclk) begin
			rx_sh = {rx_sh[6:0], mmc_do};
			bit_cnt++;
			if (bit_cnt % 8 == 0)
				take_byte(rx_sh);
		end else begin
			// Next bit out on the falling edge
			if (bit_cnt % 8 == 0) begin
				if (out_q.size() > 0)
					tx_sh = out_q.pop_front();
				else
					tx_sh = BYTE_IDLE;
			end else begin
				tx_sh = {tx_sh[6:0], 1'b1};
			end
			mmc_di = tx_sh[7];
		end
	end

endmodule

// ==== dv/tb_block_dev_mmc.sv ====
// Default DUT parameters only, the local copies of SCLK_HALF and BLOCKS_PER_REQ track them
`timescale 1ns/1ps

module tb_block_dev_mmc;
	import mmc_pkg::*;

	localparam int CLK_PERIOD_NS = 4;
	localparam int SCLK_HALF = 2;
	localparam int BLOCKS_PER_REQ = 2;
	localparam int WORDS_PER_REQ = BLOCKS_PER_REQ * 256;
	localparam logic [22:0] POISON_BLOCK = 23'h2d_0bad;
	// Wake, then CMD0, three CMD1 and CMD16 each with response and stop
	localparam int INIT_BYTES = 10 + 5 * 8;
	// Dummy, CMD17, R1, token, data, CRC and stop
	localparam int BLOCK_SPI_BYTES = 6 + 6 + 1 + 1 + 512 + 2 + 1;
	localparam int REQ_BYTES = INIT_BYTES + BLOCKS_PER_REQ * BLOCK_SPI_BYTES;
	localparam int NUM_REQS = 5;
	localparam int SCLK_PERIOD_NS = 2 * SCLK_HALF * CLK_PERIOD_NS;
	localparam longint WATCHDOG_NS = 2 * NUM_REQS * REQ_BYTES * 8 * SCLK_PERIOD_NS;

	logic        clk;
	logic        reset;
	logic [1:0]  bd_cmd;
	logic [22:0] bd_addr;
	logic        bd_start;
	logic        bd_rd;
	logic        mmc_di;
	logic [15:0] bd_data_out;
	logic        bd_bsy;
	logic        bd_rdy;
	logic        bd_iordy;
	logic        bd_err;
	logic        mmc_cs;
	logic        mmc_do;
	logic        mmc_sclk;
	integer      seed;
	logic [22:0] blk;

	block_dev_mmc i_dut (
		.clk         (clk),
		.reset       (reset),
		.bd_cmd      (bd_cmd),
		.bd_addr     (bd_addr),
		.bd_start    (bd_start),
		.bd_rd       (bd_rd),
		.mmc_di      (mmc_di),
		.bd_data_out (bd_data_out),
		.bd_bsy      (bd_bsy),
		.bd_rdy      (bd_rdy),
		.bd_iordy    (bd_iordy),
		.bd_err      (bd_err),
		.mmc_cs      (mmc_cs),
		.mmc_do      (mmc_do),
		.mmc_sclk    (mmc_sclk)
	);

	sd_card_model #(
		.POISON_ADDR ({POISON_BLOCK, 9'd0})
	) i_card (
		.mmc_cs   (mmc_cs),
		.mmc_sclk (mmc_sclk),
		.mmc_do   (mmc_do),
		.mmc_di   (mmc_di)
	);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic expect_equal(input string test, input logic [39:0] expected,
			input logic [39:0] actual);
		assert (actual === expected)
			else fail_now($sformatf("Mismatch %s expected %0h actual %0h", test, expected, actual));
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_now($sformatf("Timeout after %0d ns, a request never finished", WATCHDOG_NS));
	end

	err_one_cycle: assert property (@(posedge clk) disable iff (reset) bd_err |=> !bd_err)
		else fail_now("bd_err stayed high for more than one cycle");
	offer_keeps_rdy: assert property (@(posedge clk) disable iff (reset) bd_iordy |-> bd_rdy)
		else fail_now("bd_rdy was low while a word was on offer");

	task automatic apply_reset();
		reset = 1'b1;
		bd_start = 1'b0;
		bd_rd = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic idle_pin_check(input string test);
		expect_equal({test, "_cs"}, 1, mmc_cs);
		expect_equal({test, "_sclk"}, 0, mmc_sclk);
		expect_equal({test, "_do"}, 1, mmc_do);
		expect_equal({test, "_bsy"}, 0, bd_bsy);
		expect_equal({test, "_iordy"}, 0, bd_iordy);
		expect_equal({test, "_err"}, 0, bd_err);
		expect_equal({test, "_rdy"}, 1, bd_rdy);
	endtask

	task automatic pick_block(output logic [22:0] picked);
		picked = 23'($random(seed));
		// Neither block of the request may hit the poisoned one
		while (picked == POISON_BLOCK || picked + 23'd1 == POISON_BLOCK)
			picked = 23'($random(seed));
	endtask

	// Busy shows on the second edge after the one that samples the start pulse
	task automatic issue_start(input string test, input host_cmd_e cmd, input logic [22:0] addr);
		bd_cmd = cmd;
		bd_addr = addr;
		bd_start = 1'b1;
		@(posedge clk);
		#1;
		bd_start = 1'b0;
		expect_equal({test, "_bsy_early"}, 0, bd_bsy);
		@(posedge clk);
		#1;
		expect_equal({test, "_bsy_early"}, 0, bd_bsy);
		@(posedge clk);
		#1;
		expect_equal({test, "_bsy_rise"}, 1, bd_bsy);
	endtask

	task automatic expect_frame(input string test, inout int idx, input logic [7:0] index,
			input logic [31:0] arg);
		if (idx >= i_card.log_count)
			fail_now($sformatf("%s: the card received fewer frames than expected", test));
		else
			expect_equal($sformatf("%s_frame%0d", test, idx), {index, arg}, i_card.log_mem[idx]);
		idx++;
	endtask

	task automatic run_request(input string test, input host_cmd_e cmd, input logic [22:0] addr,
			input bit cold, input bit poisoned);
		int          words;
		int          err_cycles;
		int          pause;
		int          idx;
		int          n_blocks;
		int          b;
		logic [31:0] base;
		logic [31:0] off;
		logic [15:0] exp_word;
		words = 0;
		err_cycles = 0;
		idx = i_card.log_count;
		issue_start(test, cmd, addr);
		while (bd_bsy) begin
			if (bd_err)
				err_cycles++;
			if (bd_iordy) begin
				// Each card byte is the low byte of its byte address
				base = {addr, 9'd0} + 32'(words / 256) * 32'd512;
				off = 32'((words % 256) * 2);
				exp_word = {8'(base + off + 32'd1), 8'(base + off)};
				expect_equal($sformatf("%s_word%0d", test, words), exp_word, bd_data_out);
				pause = $random(seed) & 3;
				repeat (pause) begin
					@(posedge clk);
					#1;
					expect_equal({test, "_iordy_hold"}, 1, bd_iordy);
				end
				bd_rd = 1'b1;
				@(posedge clk);
				#1;
				bd_rd = 1'b0;
				expect_equal({test, "_iordy_fall"}, 0, bd_iordy);
				words++;
			end else begin
				@(posedge clk);
				#1;
			end
		end
		expect_equal({test, "_words"}, (cmd == cmd_read && !poisoned) ? WORDS_PER_REQ : 0, words);
		expect_equal({test, "_err_cycles"}, poisoned, err_cycles);
		expect_equal({test, "_err_end"}, 0, bd_err);
		// Frames the card saw during this request
		if (cold) begin
			expect_frame(test, idx, 8'h40, 32'd0);
			repeat (3) expect_frame(test, idx, 8'h41, 32'd0);
			expect_frame(test, idx, 8'h50, 32'd512);
		end
		if (cmd == cmd_read) begin
			n_blocks = poisoned ? 1 : BLOCKS_PER_REQ;
			for (b = 0; b < n_blocks; b++)
				expect_frame(test, idx, 8'h51, {addr, 9'd0} + 32'(b) * 32'd512);
		end
		expect_equal({test, "_frame_count"}, idx, i_card.log_count);
	endtask

	initial begin
		seed = 32'h924d_1e4e;
		reset = 1'b1;
		bd_cmd = cmd_reset;
		bd_addr = '0;
		bd_start = 1'b0;
		bd_rd = 1'b0;
		apply_reset();
		idle_pin_check("after_reset");
		run_request("init", cmd_reset, '0, 1'b1, 1'b0);
		pick_block(blk);
		run_request("read_a", cmd_read, blk, 1'b0, 1'b0);
		pick_block(blk);
		run_request("read_b", cmd_read, blk, 1'b0, 1'b0);
		run_request("read_poison", cmd_read, POISON_BLOCK, 1'b0, 1'b1);
		// Card state lost, so the next read initialises first
		apply_reset();
		idle_pin_check("second_reset");
		pick_block(blk);
		run_request("cold_read", cmd_read, blk, 1'b1, 1'b0);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== Bender.yml ====
package:
  name: block_dev_mmc

sources:
  - files:
      - verilog/mmc_pkg.sv
      - verilog/spi_byte_engine.sv
      - verilog/blk_cmd_decode.sv
      - verilog/blk_sequencer.sv
      - verilog/blk_read_result.sv
      - verilog/block_dev_mmc.sv
  - target: simulation
    files:
      - dv/sd_card_model.sv
      - dv/tb_block_dev_mmc.sv

// ==== sim.f ====
verilog/mmc_pkg.sv
verilog/spi_byte_engine.sv
verilog/blk_cmd_decode.sv
verilog/blk_sequencer.sv
verilog/blk_read_result.sv
verilog/block_dev_mmc.sv
dv/sd_card_model.sv
dv/tb_block_dev_mmc.sv
